/* snoop_pkg.sv */
package snoop_pkg;

    // Number of filter cores behind the snoop arbiter
    localparam int N_CORES = 4;
    // Tag addresses one core
    localparam int TAG_SZ = 2;

    // Snooper bus widths
    localparam int SN_ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 64;
    localparam int INC_WIDTH = 8;

    // Per-packet byte total and checked field widths
    localparam int BYTES_WIDTH = 16;
    localparam int RULE_WIDTH = 16;

    typedef logic [SN_ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [INC_WIDTH-1:0] inc_t;
    typedef logic [TAG_SZ-1:0] tag_t;
    typedef logic [N_CORES-1:0] core_vec_t;
    typedef logic [BYTES_WIDTH-1:0] bytes_t;
    typedef logic [RULE_WIDTH-1:0] rule_t;

    // Filter rule, low 16 bits of word 1 must hold this protocol value
    localparam addr_t RULE_ADDR = addr_t'(1);
    localparam rule_t RULE_VALUE = 16'h0800;

    // Processing time of a core after done
    localparam int PROC_CYCLES = 6;
    localparam int PROC_CNT_W = $clog2(PROC_CYCLES + 1);

    typedef logic [PROC_CNT_W-1:0] proc_cnt_t;

endpackage

/* tag_tree.sv */
module tag_tree (
    // One ready flag per core
    input  snoop_pkg::core_vec_t rdy_in_i,
    // Acknowledge from the snooper
    input  logic                 ack_i,
    // Winning core and its ready flag
    output snoop_pkg::tag_t      tag_o,
    output logic                 rdy_o,
    // Acknowledge steered to the winner only
    output snoop_pkg::core_vec_t ack_out_o
);

    // Heap-ordered tree
    // Node k has children 2k and 2k+1, leaves sit at N_CORES .. 2*N_CORES-1
    wire                  node_rdy [1:2*snoop_pkg::N_CORES-1];
    wire snoop_pkg::tag_t node_tag [1:2*snoop_pkg::N_CORES-1];
    wire                  node_ack [1:2*snoop_pkg::N_CORES-1];

    genvar i;

    generate
        // Leaves carry the core ready flag and a constant tag
        for (i = 0; i < snoop_pkg::N_CORES; i++) begin : g_leaf
            assign node_rdy[snoop_pkg::N_CORES + i] = rdy_in_i[i];
            assign node_tag[snoop_pkg::N_CORES + i] = snoop_pkg::tag_t'(i);
        end

        // Inner nodes merge two children
        for (i = 1; i < snoop_pkg::N_CORES; i++) begin : g_node
            // Ready if either side has a ready core
            assign node_rdy[i] = node_rdy[2*i] | node_rdy[2*i+1];
            // Lower index child wins whenever it is ready
            assign node_tag[i] = node_rdy[2*i] ? node_tag[2*i] : node_tag[2*i+1];
            // Ack follows the same decision back down
            assign node_ack[2*i] = node_ack[i] & node_rdy[2*i];
            assign node_ack[2*i+1] = node_ack[i] & !node_rdy[2*i] & node_rdy[2*i+1];
        end
    endgenerate

    // Root of the tree faces the snooper
    assign node_ack[1] = ack_i;
    assign rdy_o = node_rdy[1];
    assign tag_o = node_tag[1];

    // Leaf acks go back out, at most one bit set
    always_comb begin
        for (int k = 0; k < snoop_pkg::N_CORES; k++) begin
            ack_out_o[k] = node_ack[snoop_pkg::N_CORES + k];
        end
    end

endmodule

/* snoop_arb.sv */
module snoop_arb (
    input  logic                 clk,
    input  logic                 rst,

    // Snooper side
    input  snoop_pkg::addr_t     addr_i,
    input  snoop_pkg::data_t     wr_data_i,
    input  logic                 wr_en_i,
    input  snoop_pkg::inc_t      byte_inc_i,
    input  logic                 done_i,
    input  logic                 ack_i,
    output logic                 rdy_o,

    // Filter core side
    input  snoop_pkg::core_vec_t rdy_for_sn_i,
    output snoop_pkg::addr_t     sn_addr_o,
    output snoop_pkg::data_t     sn_wr_data_o,
    output snoop_pkg::core_vec_t sn_wr_en_o,
    output snoop_pkg::inc_t      sn_byte_inc_o,
    output snoop_pkg::core_vec_t sn_done_o,
    output snoop_pkg::core_vec_t rdy_for_sn_ack_o
);

    // Tag chosen by the tree this cycle
    snoop_pkg::tag_t sel_next;
    // Core that owns the current packet
    snoop_pkg::tag_t sel_q;

    // Tree finds the lowest ready core and routes ack to it
    tag_tree u_tag_tree (
        .rdy_in_i  (rdy_for_sn_i),
        .ack_i     (ack_i),
        .tag_o     (sel_next),
        .rdy_o     (rdy_o),
        .ack_out_o (rdy_for_sn_ack_o)
    );

    // Capture the winner on the handshake edge
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else if (rdy_o && ack_i) begin
            sel_q <= sel_next;
        end
    end

    // Wide buses go to every core, only the owner acts on them
    assign sn_addr_o = addr_i;
    assign sn_wr_data_o = wr_data_i;
    assign sn_byte_inc_o = byte_inc_i;

    // Write enable and done reach the owning core only
    always_comb begin
        for (int i = 0; i < snoop_pkg::N_CORES; i++) begin
            sn_wr_en_o[i] = wr_en_i && (sel_q == snoop_pkg::tag_t'(i));
            sn_done_o[i] = done_i && (sel_q == snoop_pkg::tag_t'(i));
        end
    end

endmodule

/* snooper.sv */
module snooper (
    input  logic             clk,
    input  logic             rst,

    // Input packet stream
    input  snoop_pkg::data_t in_data_i,
    input  snoop_pkg::inc_t  in_bytes_i,
    input  logic             in_last_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,

    // Toward the snoop arbiter
    input  logic             rdy_i,
    output logic             ack_o,
    output snoop_pkg::addr_t addr_o,
    output snoop_pkg::data_t wr_data_o,
    output logic             wr_en_o,
    output snoop_pkg::inc_t  byte_inc_o,
    output logic             done_o
);

    typedef enum logic {
        SN_IDLE,
        SN_SEND
    } snoop_state_t;

    snoop_state_t     state;
    // Buffer address of the next word
    snoop_pkg::addr_t word_addr;
    // Word moves from the stream to a core this cycle
    logic             take;

    always_comb begin
        // Ask for a core as soon as a first word waits
        ack_o = (state == SN_IDLE) && in_valid_i;
        // Input is held back until a core owns the packet
        in_ready_o = (state == SN_SEND) && in_valid_i;
        take = (state == SN_SEND) && in_valid_i;
        wr_en_o = take;
        // Done rides along with the last write
        done_o = take && in_last_i;
        addr_o = word_addr;
        wr_data_o = in_data_i;
        byte_inc_o = in_bytes_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SN_IDLE;
            word_addr <= '0;
        end else begin
            case (state)
                SN_IDLE: begin
                    if (ack_o && rdy_i) begin
                        state <= SN_SEND;
                        word_addr <= '0;
                    end
                end
                SN_SEND: begin
                    // A gap in valid just pauses the writes
                    if (take) begin
                        word_addr <= word_addr + 1'b1;
                        if (in_last_i) begin
                            state <= SN_IDLE;
                        end
                    end
                end
                default: state <= SN_IDLE;
            endcase
        end
    end

endmodule

/* filter_core.sv */
module filter_core (
    input  logic              clk,
    input  logic              rst,

    // Snooper bus from the arbiter
    input  snoop_pkg::addr_t  sn_addr_i,
    input  snoop_pkg::data_t  sn_wr_data_i,
    input  logic              sn_wr_en_i,
    input  snoop_pkg::inc_t   sn_byte_inc_i,
    input  logic              sn_done_i,
    input  logic              ack_i,
    output logic              rdy_for_sn_o,

    // Result toward the result arbiter
    output logic              res_valid_o,
    output logic              res_accept_o,
    output snoop_pkg::bytes_t res_bytes_o,
    input  logic              res_take_i
);

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_LOAD,
        CORE_WORK,
        CORE_HOLD
    } core_state_t;

    core_state_t           state;
    // Running byte count of the packet being loaded
    snoop_pkg::bytes_t     byte_total;
    // Checked field and whether it has been written yet
    snoop_pkg::rule_t      rule_word;
    logic                  rule_seen;
    snoop_pkg::proc_cnt_t  work_cnt;
    // Held verdict
    logic                  res_accept;
    snoop_pkg::bytes_t     res_bytes;

    // Values including the write of this cycle
    logic                  rule_hit;
    logic                  cur_seen;
    snoop_pkg::rule_t      cur_word;
    snoop_pkg::bytes_t     cur_total;

    always_comb begin
        rule_hit = sn_wr_en_i && (sn_addr_i == snoop_pkg::RULE_ADDR);
        cur_seen = rule_seen || rule_hit;
        cur_word = rule_hit ? sn_wr_data_i[snoop_pkg::RULE_WIDTH-1:0] : rule_word;
        cur_total = sn_wr_en_i ? byte_total + snoop_pkg::bytes_t'(sn_byte_inc_i) : byte_total;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CORE_IDLE;
            rule_seen <= 1'b0;
            work_cnt <= '0;
        end else begin
            case (state)
                CORE_IDLE: begin
                    if (ack_i) begin
                        state <= CORE_LOAD;
                        rule_seen <= 1'b0;
                    end
                end
                CORE_LOAD: begin
                    rule_seen <= cur_seen;
                    if (sn_done_i) begin
                        state <= CORE_WORK;
                        work_cnt <= snoop_pkg::proc_cnt_t'(snoop_pkg::PROC_CYCLES);
                    end
                end
                CORE_WORK: begin
                    // Count down, result shows after the zero cycle
                    if (work_cnt == '0) begin
                        state <= CORE_HOLD;
                    end else begin
                        work_cnt <= work_cnt - 1'b1;
                    end
                end
                CORE_HOLD: begin
                    if (res_take_i) begin
                        state <= CORE_IDLE;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (state == CORE_IDLE && ack_i) begin
            byte_total <= '0;
        end else if (state == CORE_LOAD) begin
            byte_total <= cur_total;
        end
        if (state == CORE_LOAD && rule_hit) begin
            rule_word <= sn_wr_data_i[snoop_pkg::RULE_WIDTH-1:0];
        end
        // Short packets never write the rule word and are rejected
        if (state == CORE_LOAD && sn_done_i) begin
            res_accept <= cur_seen && (cur_word == snoop_pkg::RULE_VALUE);
            res_bytes <= cur_total;
        end
    end

    assign rdy_for_sn_o = (state == CORE_IDLE);
    assign res_valid_o = (state == CORE_HOLD);
    assign res_accept_o = res_accept;
    assign res_bytes_o = res_bytes;

endmodule

/* result_arb.sv */
module result_arb (
    input  logic                                         clk,
    input  logic                                         rst,

    // Per-core results
    input  snoop_pkg::core_vec_t                         res_valid_i,
    input  snoop_pkg::core_vec_t                         res_accept_i,
    input  snoop_pkg::bytes_t [snoop_pkg::N_CORES-1:0]   res_bytes_i,
    output snoop_pkg::core_vec_t                         res_take_o,

    // Output result stream
    output logic                                         out_valid_o,
    output logic                                         out_accept_o,
    output snoop_pkg::bytes_t                            out_bytes_o,
    output snoop_pkg::tag_t                              out_core_o,
    input  logic                                         out_ready_i
);

    // Core with the highest priority this round
    snoop_pkg::tag_t ptr;
    // Core being offered and the candidate under test
    snoop_pkg::tag_t sel;
    snoop_pkg::tag_t idx;
    logic            found;

    // Search from the pointer upward, wrapping around
    always_comb begin
        found = 1'b0;
        sel = ptr;
        idx = ptr;
        for (int k = 0; k < snoop_pkg::N_CORES; k++) begin
            idx = snoop_pkg::tag_t'((int'(ptr) + k) % snoop_pkg::N_CORES);
            if (!found && res_valid_i[idx]) begin
                found = 1'b1;
                sel = idx;
            end
        end
    end

    assign out_valid_o = found;
    assign out_core_o = sel;
    assign out_accept_o = res_accept_i[sel];
    assign out_bytes_o = res_bytes_i[sel];
    // Take pulse frees the core on the transfer cycle
    assign res_take_o = (found && out_ready_i) ? snoop_pkg::core_vec_t'(1) << sel : '0;

    // Next round starts just past the core that was served
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (found && out_ready_i) begin
            ptr <= snoop_pkg::tag_t'((int'(sel) + 1) % snoop_pkg::N_CORES);
        end
    end

endmodule

/* snoop_top.sv */
module snoop_top (
    input  logic              clk,
    input  logic              rst,

    // Packet input stream
    input  snoop_pkg::data_t  in_data_i,
    input  snoop_pkg::inc_t   in_bytes_i,
    input  logic              in_last_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,

    // Verdict output stream
    output logic              out_valid_o,
    output logic              out_accept_o,
    output snoop_pkg::bytes_t out_bytes_o,
    output snoop_pkg::tag_t   out_core_o,
    input  logic              out_ready_i
);

    // Snooper to arbiter
    wire snoop_pkg::addr_t                        addr;
    wire snoop_pkg::data_t                        wr_data;
    wire                                          wr_en;
    wire snoop_pkg::inc_t                         byte_inc;
    wire                                          done;
    wire                                          ack;
    wire                                          rdy;

    // Arbiter to cores
    wire snoop_pkg::addr_t                        sn_addr;
    wire snoop_pkg::data_t                        sn_wr_data;
    wire snoop_pkg::core_vec_t                    sn_wr_en;
    wire snoop_pkg::inc_t                         sn_byte_inc;
    wire snoop_pkg::core_vec_t                    sn_done;
    wire snoop_pkg::core_vec_t                    rdy_for_sn;
    wire snoop_pkg::core_vec_t                    rdy_for_sn_ack;

    // Cores to result arbiter
    wire snoop_pkg::core_vec_t                    res_valid;
    wire snoop_pkg::core_vec_t                    res_accept;
    wire snoop_pkg::bytes_t [snoop_pkg::N_CORES-1:0] res_bytes;
    wire snoop_pkg::core_vec_t                    res_take;

    snooper u_snooper (
        .clk        (clk),
        .rst        (rst),
        .in_data_i  (in_data_i),
        .in_bytes_i (in_bytes_i),
        .in_last_i  (in_last_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .rdy_i      (rdy),
        .ack_o      (ack),
        .addr_o     (addr),
        .wr_data_o  (wr_data),
        .wr_en_o    (wr_en),
        .byte_inc_o (byte_inc),
        .done_o     (done)
    );

    snoop_arb u_snoop_arb (
        .clk              (clk),
        .rst              (rst),
        .addr_i           (addr),
        .wr_data_i        (wr_data),
        .wr_en_i          (wr_en),
        .byte_inc_i       (byte_inc),
        .done_i           (done),
        .ack_i            (ack),
        .rdy_o            (rdy),
        .rdy_for_sn_i     (rdy_for_sn),
        .sn_addr_o        (sn_addr),
        .sn_wr_data_o     (sn_wr_data),
        .sn_wr_en_o       (sn_wr_en),
        .sn_byte_inc_o    (sn_byte_inc),
        .sn_done_o        (sn_done),
        .rdy_for_sn_ack_o (rdy_for_sn_ack)
    );

    // One filter core per arbiter slot
    for (genvar c = 0; c < snoop_pkg::N_CORES; c++) begin : g_core
        filter_core u_core (
            .clk           (clk),
            .rst           (rst),
            .sn_addr_i     (sn_addr),
            .sn_wr_data_i  (sn_wr_data),
            .sn_wr_en_i    (sn_wr_en[c]),
            .sn_byte_inc_i (sn_byte_inc),
            .sn_done_i     (sn_done[c]),
            .ack_i         (rdy_for_sn_ack[c]),
            .rdy_for_sn_o  (rdy_for_sn[c]),
            .res_valid_o   (res_valid[c]),
            .res_accept_o  (res_accept[c]),
            .res_bytes_o   (res_bytes[c]),
            .res_take_i    (res_take[c])
        );
    end

    result_arb u_result_arb (
        .clk          (clk),
        .rst          (rst),
        .res_valid_i  (res_valid),
        .res_accept_i (res_accept),
        .res_bytes_i  (res_bytes),
        .res_take_o   (res_take),
        .out_valid_o  (out_valid_o),
        .out_accept_o (out_accept_o),
        .out_bytes_o  (out_bytes_o),
        .out_core_o   (out_core_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

/* snoop_tb.sv */
module snoop_tb;

    logic              clk = 1'b0;
    logic              rst;
    snoop_pkg::data_t  in_data;
    snoop_pkg::inc_t   in_bytes;
    logic              in_last;
    logic              in_valid;
    logic              in_ready;
    logic              out_valid;
    logic              out_accept;
    snoop_pkg::bytes_t out_bytes;
    snoop_pkg::tag_t   out_core;
    logic              out_ready = 1'b0;

    integer seed = 32'h0458_0de9;
    // 0 holds out_ready low, 1 holds it high, 2 toggles it at random
    int ready_mode = 1;
    int errors = 0;
    int checks = 0;
    int results = 0;
    int base_errors = 0;
    int cycles = 0;
    int cycle_limit = 0;
    // Expected {accept, bytes} of every packet still in flight
    logic [16:0] expect_q[$];
    // Core index of every transfer, in output order
    int core_log[$];
    // Packet lengths of the whole run, drawn up front
    int lens[$];
    int len_idx = 0;

    snoop_top UUT (
        .clk          (clk),
        .rst          (rst),
        .in_data_i    (in_data),
        .in_bytes_i   (in_bytes),
        .in_last_i    (in_last),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .out_valid_o  (out_valid),
        .out_accept_o (out_accept),
        .out_bytes_o  (out_bytes),
        .out_core_o   (out_core),
        .out_ready_i  (out_ready)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // Output back-pressure, changed on the falling edge
    always @(negedge clk) begin
        case (ready_mode)
            0: out_ready = 1'b0;
            1: out_ready = 1'b1;
            default: out_ready = ($unsigned($random(seed)) % 3) != 0;
        endcase
    end

    // A held result stays offered until it is taken
    assert property (@(posedge clk) disable iff (rst) out_valid && !out_ready |=> out_valid)
    else begin
        $display("Result withdrawn from out_valid_o before it was taken");
        errors++;
    end

    // Every transfer must match one packet still expected, in any order
    always @(posedge clk) begin : monitor
        int hit_idx;
        if (!rst && out_valid && out_ready) begin
            hit_idx = -1;
            foreach (expect_q[k]) begin
                if (hit_idx < 0 && expect_q[k] == {out_accept, out_bytes}) begin
                    hit_idx = k;
                end
            end
            checks++;
            assert (hit_idx >= 0) else begin
                $display("CHECK FAILED out_accept_o/out_bytes_o: got %h/%h, no packet expects it",
                         out_accept, out_bytes);
                errors++;
            end
            if (hit_idx >= 0) begin
                expect_q.delete(hit_idx);
            end
            core_log.push_back(int'(out_core));
            results++;
        end
    end

    // Ends a run that stops making progress
    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d results still missing",
                 cycles, expect_q.size());
        $display("Testbench failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    // Offers one word and returns once the snooper has taken it
    task automatic drive_word(input snoop_pkg::data_t data, input snoop_pkg::inc_t nbytes,
                              input logic last);
        @(negedge clk);
        in_data = data;
        in_bytes = nbytes;
        in_last = last;
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // Sends the next packet length from the list and queues its verdict
    task automatic send_packet(input bit hit, input bit gaps);
        snoop_pkg::data_t  word;
        snoop_pkg::inc_t   nbytes;
        snoop_pkg::bytes_t total;
        logic              accept;
        int                len;
        len = lens[len_idx];
        len_idx++;
        total = '0;
        // Stays low for packets that end before the rule word
        accept = 1'b0;
        for (int i = 0; i < len; i++) begin
            word = {$random(seed), $random(seed)};
            nbytes = snoop_pkg::inc_t'(1 + $unsigned($random(seed)) % 8);
            if (i == int'(snoop_pkg::RULE_ADDR)) begin
                if (hit) begin
                    word[15:0] = snoop_pkg::RULE_VALUE;
                end else if (word[15:0] == snoop_pkg::RULE_VALUE) begin
                    word[0] = ~word[0];
                end
                accept = hit;
            end
            total = total + snoop_pkg::bytes_t'(nbytes);
            if (gaps && ($unsigned($random(seed)) % 4) == 0) begin
                idle_cycles(1 + $unsigned($random(seed)) % 2);
            end
            drive_word(word, nbytes, i == len - 1);
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_last = 1'b0;
        expect_q.push_back({accept, total});
    endtask

    task automatic wait_drain();
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, errors - base_errors);
        base_errors = errors;
    endtask

    initial begin : main
        snoop_pkg::inc_t nbytes;
        bit              hit;
        int              limit_sum;
        rst = 1'b1;
        in_data = '0;
        in_bytes = '0;
        in_last = 1'b0;
        in_valid = 1'b0;
        // Fixed lengths of tests 1 and 2, then random ones for tests 3 to 5
        lens = {1, 3, 4, 1, 2};
        repeat (53) lens.push_back(1 + int'($unsigned($random(seed)) % 12));
        limit_sum = 200;
        foreach (lens[k]) begin
            limit_sum += lens[k] + snoop_pkg::PROC_CYCLES + 10;
        end
        cycle_limit = limit_sum;
        apply_reset();

        // Test 1, idle outputs, then ready only after the handshake cycle
        repeat (3) begin
            @(posedge clk);
            check_value("out_valid_o", out_valid, 0);
            check_value("in_ready_o", in_ready, 0);
        end
        nbytes = snoop_pkg::inc_t'(1 + $unsigned($random(seed)) % 8);
        len_idx++;
        @(negedge clk);
        in_data = {$random(seed), $random(seed)};
        in_bytes = nbytes;
        in_last = 1'b1;
        in_valid = 1'b1;
        @(posedge clk);
        check_value("in_ready_o", in_ready, 0);
        @(posedge clk);
        check_value("in_ready_o", in_ready, 1);
        @(negedge clk);
        in_valid = 1'b0;
        in_last = 1'b0;
        // One word is too short for the rule
        expect_q.push_back({1'b0, snoop_pkg::bytes_t'(nbytes)});
        wait_drain();
        report_test(1, "reset state");

        // Test 2, hit, miss, short with hit value, shortest hit
        send_packet(1'b1, 1'b0);
        wait_drain();
        send_packet(1'b0, 1'b0);
        wait_drain();
        send_packet(1'b1, 1'b0);
        wait_drain();
        send_packet(1'b1, 1'b0);
        wait_drain();
        report_test(2, "rule verdict");

        // Test 3, byte totals over random lengths
        repeat (8) begin
            hit = $unsigned($random(seed)) % 2;
            send_packet(hit, 1'b0);
        end
        wait_drain();
        report_test(3, "byte total");

        // Test 4, fresh pointer, four cores filled while output is stalled
        @(negedge clk);
        apply_reset();
        core_log.delete();
        ready_mode = 0;
        repeat (4) begin
            hit = $unsigned($random(seed)) % 2;
            send_packet(hit, 1'b0);
        end
        hit = $unsigned($random(seed)) % 2;
        fork
            send_packet(hit, 1'b0);
            begin
                // No core is free, so the fifth packet waits
                repeat (8) begin
                    @(posedge clk);
                    check_value("in_ready_o", in_ready, 0);
                end
                @(negedge clk);
                ready_mode = 1;
            end
        join
        wait_drain();
        check_value("result count", core_log.size(), 5);
        for (int k = 0; k < 5 && k < core_log.size(); k++) begin
            check_value("out_core_o", core_log[k], k % 4);
        end
        report_test(4, "core allocation");

        // Test 5, gaps on both streams
        core_log.delete();
        ready_mode = 2;
        repeat (40) begin
            hit = $unsigned($random(seed)) % 2;
            send_packet(hit, 1'b1);
        end
        ready_mode = 1;
        wait_drain();
        repeat (4) begin
            @(posedge clk);
            check_value("out_valid_o", out_valid, 0);
        end
        // Exactly one transfer per packet sent
        check_value("result count", core_log.size(), 40);
        report_test(5, "random traffic");

        $display("Checks %0d, results %0d, errors %0d", checks, results, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sources.f */
snoop_pkg.sv
tag_tree.sv
snoop_arb.sv
snooper.sv
filter_core.sv
result_arb.sv
snoop_top.sv
snoop_tb.sv
